// ==== src/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    // Longest address sequence, taken by the indirect modes
    localparam int NUM_STEPS_MAX = 4;

    // 6502 opcode layout aaabbbcc
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_u;

    typedef enum logic [3:0] {
        IMPLIED,
        IMMEDIATE,
        ZPG,
        ZPG_X,
        ZPG_Y,
        ABSOLUTE,
        ABS_X,
        ABS_Y,
        IND_X,
        IND_Y
    } addr_mode_e;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_ACC,
        ST_X,
        ST_Y
    } store_kind_e;

    typedef enum logic [1:0] {
        A0,
        A1,
        A2,
        A3
    } addr_step_e;

    // One bit per datapath control line
    typedef struct packed {
        logic pc_inc;
        logic load_abl;
        logic load_abh;
        logic set_adl_to_pcl;
        logic set_adh_to_pch;
        logic set_adl_to_data;
        logic set_adh_to_data;
        logic set_adl_to_alu;
        logic set_adh_to_sb;
        logic set_adh_low;
        logic set_db_to_data;
        logic set_db_to_acc;
        logic set_db_to_sb;
        logic set_sb_to_x;
        logic set_sb_to_y;
        logic set_sb_to_alu;
        logic set_input_a_to_sb;
        logic set_input_a_to_low;
        logic set_input_b_to_db;
        logic set_alu_carry_high;
        logic alu_add;
        logic load_alu;
        logic load_dor;
    } ctrl_flags_t;

    typedef struct packed {
        addr_mode_e  mode;
        store_kind_e store;
    } decoded_op_t;

    // One address cycle worth of control
    typedef struct packed {
        ctrl_flags_t flags;
        addr_step_e  step;
        logic        last;
    } ctrl_beat_t;

endpackage

// ==== src/opcode_decode.sv ====
`timescale 1ns/1ps

module opcode_decode import cpu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        op_valid,
    input  opcode_u     op,
    input  logic        dec_ready,
    output logic        op_ready,
    output logic        dec_valid,
    output decoded_op_t dec
);

    decoded_op_t dec_next;

    always_comb begin
        dec_next.mode  = IMPLIED;
        dec_next.store = ST_NONE;

        case (op.f.cc)
            // ALU group, all eight bbb slots are used
            2'b01: begin
                case (op.f.bbb)
                    3'b000:  dec_next.mode = IND_X;
                    3'b001:  dec_next.mode = ZPG;
                    3'b010:  dec_next.mode = IMMEDIATE;
                    3'b011:  dec_next.mode = ABSOLUTE;
                    3'b100:  dec_next.mode = IND_Y;
                    3'b101:  dec_next.mode = ZPG_X;
                    3'b110:  dec_next.mode = ABS_Y;
                    default: dec_next.mode = ABS_X;
                endcase
            end
            2'b00, 2'b10: begin
                case (op.f.bbb)
                    3'b000:  dec_next.mode = IMMEDIATE;
                    3'b001:  dec_next.mode = ZPG;
                    3'b011:  dec_next.mode = ABSOLUTE;
                    3'b101:  dec_next.mode = ZPG_X;
                    3'b111:  dec_next.mode = ABS_X;
                    default: dec_next.mode = IMPLIED;
                endcase
                // STX/LDX index through Y instead of X
                if (op.f.cc == 2'b10 && (op.f.aaa == 3'b100 || op.f.aaa == 3'b101)) begin
                    if (dec_next.mode == ZPG_X) begin
                        dec_next.mode = ZPG_Y;
                    end else if (dec_next.mode == ABS_X) begin
                        dec_next.mode = ABS_Y;
                    end
                end
            end
            default: dec_next.mode = IMPLIED;
        endcase

        // STA, STY, STX
        if (op.f.aaa == 3'b100) begin
            case (op.f.cc)
                2'b01:   dec_next.store = ST_ACC;
                2'b00:   dec_next.store = ST_Y;
                2'b10:   dec_next.store = ST_X;
                default: dec_next.store = ST_NONE;
            endcase
        end
    end

    // Free slot, or the held record leaves this cycle
    assign op_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (op_ready) begin
            dec_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            dec <= dec_next;
        end
    end

endmodule

// ==== src/addr_mode_seq.sv ====
`timescale 1ns/1ps

module addr_mode_seq import cpu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        dec_valid,
    input  decoded_op_t dec,
    input  logic        carry_in,
    input  logic        beat_ready,
    output logic        dec_ready,
    output logic        beat_valid,
    output ctrl_beat_t  beat
);

    decoded_op_t cur;
    addr_step_e  step;
    logic        busy;
    logic        last;
    logic        use_y;
    logic        beat_xfer;
    ctrl_flags_t flags;

    function automatic addr_step_e final_step(addr_mode_e mode);
        int beats;
        case (mode)
            IMPLIED, IMMEDIATE, ZPG: beats = 1;
            ZPG_X, ZPG_Y, ABSOLUTE:  beats = 2;
            ABS_X, ABS_Y:            beats = 3;
            default:                 beats = NUM_STEPS_MAX;
        endcase
        return addr_step_e'(2'(beats - 1));
    endfunction

    // Register out to the data output register
    function automatic ctrl_flags_t with_store(ctrl_flags_t f, store_kind_e kind);
        f.set_db_to_acc = (kind == ST_ACC);
        f.set_db_to_sb  = (kind == ST_X) || (kind == ST_Y);
        f.set_sb_to_x   = (kind == ST_X);
        f.set_sb_to_y   = (kind == ST_Y);
        f.load_dor      = (kind != ST_NONE);
        return f;
    endfunction

    // Only the accumulator store survives a page-crossing sequence
    function automatic ctrl_flags_t with_acc_store(ctrl_flags_t f, store_kind_e kind);
        f.set_db_to_acc = (kind == ST_ACC);
        f.load_dor      = (kind == ST_ACC);
        return f;
    endfunction

    // Data byte plus X or Y
    function automatic ctrl_flags_t with_index(ctrl_flags_t f, logic y_reg);
        f.load_alu          = 1'b1;
        f.alu_add           = 1'b1;
        f.set_db_to_data    = 1'b1;
        f.set_input_b_to_db = 1'b1;
        f.set_input_a_to_sb = 1'b1;
        f.set_sb_to_x       = !y_reg;
        f.set_sb_to_y       = y_reg;
        return f;
    endfunction

    function automatic ctrl_flags_t with_zpg(ctrl_flags_t f);
        f.set_adh_low = 1'b1;
        f.load_abh    = 1'b1;
        f.load_abl    = 1'b1;
        return f;
    endfunction

    function automatic ctrl_flags_t with_pc(ctrl_flags_t f);
        f.pc_inc         = 1'b1;
        f.set_adl_to_pcl = 1'b1;
        f.set_adh_to_pch = 1'b1;
        f.load_abl       = 1'b1;
        f.load_abh       = 1'b1;
        return f;
    endfunction

    // Data byte plus zero, carry supplied by the caller
    function automatic ctrl_flags_t with_inc(ctrl_flags_t f);
        f.set_db_to_data     = 1'b1;
        f.set_input_b_to_db  = 1'b1;
        f.set_input_a_to_low = 1'b1;
        f.load_alu           = 1'b1;
        f.alu_add            = 1'b1;
        return f;
    endfunction

    // High byte from memory, low byte from the ALU
    function automatic ctrl_flags_t with_final(ctrl_flags_t f);
        f.set_adh_to_data = 1'b1;
        f.load_abh        = 1'b1;
        f.set_adl_to_alu  = 1'b1;
        f.load_abl        = 1'b1;
        return f;
    endfunction

    assign use_y = (cur.mode == ZPG_Y) || (cur.mode == ABS_Y);

    always_comb begin
        flags = '0;
        case (cur.mode)
            IMMEDIATE: flags.pc_inc = 1'b1;
            ZPG: begin
                flags = with_zpg(flags);
                flags.set_adl_to_data = 1'b1;
                flags = with_store(flags, cur.store);
            end
            ZPG_X, ZPG_Y: begin
                if (step == A0) begin
                    flags = with_index(flags, use_y);
                end else begin
                    flags = with_zpg(flags);
                    flags.set_adl_to_alu = 1'b1;
                    flags = with_store(flags, cur.store);
                end
            end
            ABSOLUTE: begin
                if (step == A0) begin
                    flags = with_pc(flags);
                    flags.set_db_to_data    = 1'b1;
                    flags.set_input_b_to_db = 1'b1;
                end else begin
                    flags.load_abl        = 1'b1;
                    flags.set_adl_to_alu  = 1'b1;
                    flags.set_adh_to_data = 1'b1;
                    flags.load_abh        = 1'b1;
                    flags = with_store(flags, cur.store);
                end
            end
            ABS_X, ABS_Y: begin
                case (step)
                    A0: flags = with_index(with_pc(flags), use_y);
                    A1: begin
                        flags = with_index(flags, use_y);
                        flags.set_adl_to_alu = 1'b1;
                        flags.load_abl       = 1'b1;
                    end
                    default: begin
                        flags.set_sb_to_alu = 1'b1;
                        flags.set_adh_to_sb = 1'b1;
                        flags.load_abh      = 1'b1;
                        flags = with_acc_store(flags, cur.store);
                    end
                endcase
            end
            IND_X: begin
                case (step)
                    A0: begin
                        flags = with_index(flags, 1'b0);
                        flags.pc_inc = 1'b1;
                    end
                    A1: begin
                        flags = with_zpg(flags);
                        flags.set_adl_to_alu     = 1'b1;
                        // Pointer plus one, fed back through SB and DB
                        flags.set_sb_to_alu      = 1'b1;
                        flags.set_db_to_sb       = 1'b1;
                        flags.set_input_b_to_db  = 1'b1;
                        flags.set_input_a_to_low = 1'b1;
                        flags.set_alu_carry_high = 1'b1;
                        flags.alu_add            = 1'b1;
                        flags.load_alu           = 1'b1;
                    end
                    A2: begin
                        flags = with_inc(with_zpg(flags));
                        flags.set_adl_to_alu = 1'b1;
                    end
                    default: flags = with_acc_store(with_final(flags), cur.store);
                endcase
            end
            IND_Y: begin
                case (step)
                    A0: begin
                        flags = with_inc(with_zpg(flags));
                        flags.set_adl_to_data    = 1'b1;
                        flags.set_alu_carry_high = 1'b1;
                    end
                    A1: begin
                        flags = with_index(with_zpg(flags), 1'b1);
                        flags.set_adl_to_alu     = 1'b1;
                        flags.set_alu_carry_high = carry_in;
                    end
                    A2: begin
                        // High pointer byte picks up the low-byte carry
                        flags = with_inc(with_zpg(flags));
                        flags.set_adl_to_alu     = 1'b1;
                        flags.set_alu_carry_high = carry_in;
                    end
                    default: flags = with_acc_store(with_final(flags), cur.store);
                endcase
            end
            default: flags = '0;
        endcase
    end

    assign last       = (step == final_step(cur.mode));
    assign beat_valid = busy;
    assign beat_xfer  = beat_valid && beat_ready;
    assign dec_ready  = !busy || (beat_xfer && last);

    assign beat.flags = flags;
    assign beat.step  = step;
    assign beat.last  = last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            step <= A0;
        end else if (dec_valid && dec_ready) begin
            busy <= 1'b1;
            step <= A0;
        end else if (beat_xfer) begin
            if (last) begin
                busy <= 1'b0;
            end else begin
                step <= addr_step_e'(step + 2'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            cur <= dec;
        end
    end

endmodule

// ==== src/ctrl_out_slice.sv ====
`timescale 1ns/1ps

module ctrl_out_slice import cpu_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    input  ctrl_beat_t in_beat,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       out_valid,
    output ctrl_beat_t out_beat
);

    logic       skid_valid;
    ctrl_beat_t skid_beat;
    logic       in_xfer;
    logic       out_free;

    // Comes straight from a flop, cuts the path from out_ready
    assign in_ready = !skid_valid;
    assign in_xfer  = in_valid && in_ready;
    assign out_free = out_ready || !out_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_xfer;
            skid_valid <= 1'b0;
        end else if (in_xfer) begin
            // Output stalled, park the incoming beat
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_beat <= skid_valid ? skid_beat : in_beat;
        end else if (in_xfer) begin
            skid_beat <= in_beat;
        end
    end

endmodule

// ==== src/addr_ctrl_top.sv ====
`timescale 1ns/1ps

module addr_ctrl_top import cpu_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       op_valid,
    input  opcode_u    op,
    input  logic       carry_in,
    input  logic       beat_ready,
    output logic       op_ready,
    output logic       beat_valid,
    output ctrl_beat_t beat
);

    logic        dec_valid;
    logic        dec_ready;
    decoded_op_t dec;
    logic        seq_valid;
    logic        seq_ready;
    ctrl_beat_t  seq_beat;

    opcode_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op        (op),
        .dec_ready (dec_ready),
        .op_ready  (op_ready),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    addr_mode_seq u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .carry_in   (carry_in),
        .beat_ready (seq_ready),
        .dec_ready  (dec_ready),
        .beat_valid (seq_valid),
        .beat       (seq_beat)
    );

    ctrl_out_slice u_slice (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (seq_valid),
        .in_beat   (seq_beat),
        .out_ready (beat_ready),
        .in_ready  (seq_ready),
        .out_valid (beat_valid),
        .out_beat  (beat)
    );

endmodule

// ==== bench/addr_ctrl_checker.sv ====
`timescale 1ns/1ps

module addr_ctrl_checker import cpu_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       op_valid,
    input  logic       op_ready,
    input  logic       carry_in,
    input  logic       seq_xfer,
    input  logic       beat_valid,
    input  logic       beat_ready,
    input  ctrl_beat_t beat,
    input  logic       steady,
    output logic       drained,
    output int         value_errs,
    output int         other_errs
);

    typedef struct packed {
        addr_mode_e  mode;
        store_kind_e store;
        logic [2:0]  beats;
    } op_exp_t;

    op_exp_t    exp_q[$];
    logic       carry_q[$];
    op_exp_t    cur;
    logic       active;
    int         step_cnt;
    int         cycle;
    logic       reset_checked;
    logic       prev_stall;
    logic       prev_xfer;
    ctrl_beat_t prev_beat;
    logic       watch_first;
    int         first_due;

    initial begin
        value_errs    = 0;
        other_errs    = 0;
        drained       = 1'b1;
        active        = 1'b0;
        step_cnt      = 0;
        cycle         = 0;
        reset_checked = 1'b0;
        prev_stall    = 1'b0;
        prev_xfer     = 1'b0;
        watch_first   = 1'b0;
        first_due     = 0;
    end

    // Called by the testbench in table order
    task automatic expect_op(input addr_mode_e m, input store_kind_e k, input logic [2:0] n);
        op_exp_t e;
        e.mode  = m;
        e.store = k;
        e.beats = n;
        exp_q.push_back(e);
        drained = 1'b0;
    endtask

    function automatic ctrl_flags_t zpg_addr_bits();
        ctrl_flags_t f;
        f = '0;
        f.set_adh_low = 1'b1;
        f.load_abh    = 1'b1;
        f.load_abl    = 1'b1;
        return f;
    endfunction

    function automatic ctrl_flags_t pc_addr_bits();
        ctrl_flags_t f;
        f = '0;
        f.pc_inc         = 1'b1;
        f.set_adl_to_pcl = 1'b1;
        f.set_adh_to_pch = 1'b1;
        f.load_abl       = 1'b1;
        f.load_abh       = 1'b1;
        return f;
    endfunction

    function automatic ctrl_flags_t index_add_bits(input logic y);
        ctrl_flags_t f;
        f = '0;
        f.load_alu          = 1'b1;
        f.alu_add           = 1'b1;
        f.set_db_to_data    = 1'b1;
        f.set_input_b_to_db = 1'b1;
        f.set_input_a_to_sb = 1'b1;
        f.set_sb_to_x       = !y;
        f.set_sb_to_y       = y;
        return f;
    endfunction

    function automatic ctrl_flags_t inc_data_bits();
        ctrl_flags_t f;
        f = '0;
        f.set_db_to_data     = 1'b1;
        f.set_input_b_to_db  = 1'b1;
        f.set_input_a_to_low = 1'b1;
        f.load_alu           = 1'b1;
        f.alu_add            = 1'b1;
        return f;
    endfunction

    function automatic ctrl_flags_t store_bits(input store_kind_e k);
        ctrl_flags_t f;
        f = '0;
        f.set_db_to_acc = (k == ST_ACC);
        f.set_db_to_sb  = (k == ST_X) || (k == ST_Y);
        f.set_sb_to_x   = (k == ST_X);
        f.set_sb_to_y   = (k == ST_Y);
        f.load_dor      = (k != ST_NONE);
        return f;
    endfunction

    function automatic ctrl_flags_t acc_store_bits(input store_kind_e k);
        ctrl_flags_t f;
        f = '0;
        f.set_db_to_acc = (k == ST_ACC);
        f.load_dor      = (k == ST_ACC);
        return f;
    endfunction

    // Flag word for one address cycle, c is the carry seen by the sequencer
    function automatic ctrl_flags_t expected_flags(input addr_mode_e m, input addr_step_e s,
                                                   input store_kind_e k, input logic c);
        ctrl_flags_t f;
        logic        y;
        f = '0;
        y = (m == ZPG_Y) || (m == ABS_Y);
        case (m)
            IMMEDIATE: f.pc_inc = 1'b1;
            ZPG: begin
                f = ctrl_flags_t'(zpg_addr_bits() | store_bits(k));
                f.set_adl_to_data = 1'b1;
            end
            ZPG_X, ZPG_Y: begin
                if (s == A0) begin
                    f = index_add_bits(y);
                end else begin
                    f = ctrl_flags_t'(zpg_addr_bits() | store_bits(k));
                    f.set_adl_to_alu = 1'b1;
                end
            end
            ABSOLUTE: begin
                if (s == A0) begin
                    f = pc_addr_bits();
                    f.set_db_to_data    = 1'b1;
                    f.set_input_b_to_db = 1'b1;
                end else begin
                    f = store_bits(k);
                    f.load_abl        = 1'b1;
                    f.set_adl_to_alu  = 1'b1;
                    f.set_adh_to_data = 1'b1;
                    f.load_abh        = 1'b1;
                end
            end
            ABS_X, ABS_Y: begin
                if (s == A0) begin
                    f = ctrl_flags_t'(pc_addr_bits() | index_add_bits(y));
                end else if (s == A1) begin
                    f = index_add_bits(y);
                    f.set_adl_to_alu = 1'b1;
                    f.load_abl       = 1'b1;
                end else begin
                    f = acc_store_bits(k);
                    f.set_sb_to_alu = 1'b1;
                    f.set_adh_to_sb = 1'b1;
                    f.load_abh      = 1'b1;
                end
            end
            IND_X, IND_Y: begin
                if (s == A3) begin
                    f = acc_store_bits(k);
                    f.set_adh_to_data = 1'b1;
                    f.load_abh        = 1'b1;
                    f.set_adl_to_alu  = 1'b1;
                    f.load_abl        = 1'b1;
                end else if (s == A2) begin
                    f = ctrl_flags_t'(zpg_addr_bits() | inc_data_bits());
                    f.set_adl_to_alu     = 1'b1;
                    f.set_alu_carry_high = (m == IND_Y) ? c : 1'b0;
                end else if (m == IND_X && s == A0) begin
                    f = index_add_bits(1'b0);
                    f.pc_inc = 1'b1;
                end else if (m == IND_X) begin
                    f = zpg_addr_bits();
                    f.set_adl_to_alu     = 1'b1;
                    f.set_sb_to_alu      = 1'b1;
                    f.set_db_to_sb       = 1'b1;
                    f.set_input_b_to_db  = 1'b1;
                    f.set_input_a_to_low = 1'b1;
                    f.set_alu_carry_high = 1'b1;
                    f.alu_add            = 1'b1;
                    f.load_alu           = 1'b1;
                end else if (s == A0) begin
                    f = ctrl_flags_t'(zpg_addr_bits() | inc_data_bits());
                    f.set_adl_to_data    = 1'b1;
                    f.set_alu_carry_high = 1'b1;
                end else begin
                    f = ctrl_flags_t'(zpg_addr_bits() | index_add_bits(1'b1));
                    f.set_adl_to_alu     = 1'b1;
                    f.set_alu_carry_high = c;
                end
            end
            default: f = '0;
        endcase
        return f;
    endfunction

    task automatic check_beat();
        ctrl_flags_t exp_f;
        addr_step_e  exp_step;
        logic        exp_last;
        logic        c;
        c = 1'b0;
        if (carry_q.size() == 0) begin
            other_errs++;
            $display("A beat left the DUT that never passed the sequencer output");
        end else begin
            c = carry_q.pop_front();
        end
        if (!active) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("A beat arrived while no opcode was outstanding");
                return;
            end
            cur      = exp_q.pop_front();
            step_cnt = 0;
            active   = 1'b1;
        end
        exp_step = addr_step_e'(step_cnt[1:0]);
        exp_last = (step_cnt == cur.beats - 1);
        exp_f    = expected_flags(cur.mode, exp_step, cur.store, c);
        if (beat.flags !== exp_f) begin
            value_errs++;
            $display("[ERROR] beat.flags expected 0x%h actual 0x%h (%s step %0d)",
                     exp_f, beat.flags, cur.mode.name(), step_cnt);
        end
        if (beat.step !== exp_step) begin
            value_errs++;
            $display("[ERROR] beat.step expected 0x%h actual 0x%h (%s)",
                     exp_step, beat.step, cur.mode.name());
        end
        if (beat.last !== exp_last) begin
            value_errs++;
            $display("[ERROR] beat.last expected 0x%h actual 0x%h (%s step %0d)",
                     exp_last, beat.last, cur.mode.name(), step_cnt);
        end
        step_cnt++;
        if (exp_last) begin
            active = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            cycle++;
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!op_ready || beat_valid) begin
                    other_errs++;
                    $display("After reset op_ready is %b and beat_valid is %b", op_ready, beat_valid);
                end
            end
            // Stalled beat must hold
            if (prev_stall && !beat_valid) begin
                other_errs++;
                $display("beat_valid dropped before the stalled beat was taken");
            end else if (prev_stall && beat !== prev_beat) begin
                value_errs++;
                $display("[ERROR] beat expected 0x%h actual 0x%h while stalled", prev_beat, beat);
            end
            if (steady && prev_xfer && !beat_valid && (active || exp_q.size() > 0)) begin
                other_errs++;
                $display("Gap in the beat stream while beat_ready was held high");
            end
            // Empty pipeline, so this opcode's first beat has a fixed latency
            if (steady && op_valid && op_ready && !active && exp_q.size() == 1) begin
                watch_first = 1'b1;
                first_due   = cycle + 3;
            end
            if (seq_xfer) begin
                carry_q.push_back(carry_in);
            end
            if (beat_valid && beat_ready) begin
                check_beat();
            end
            if (watch_first && ((beat_valid && beat_ready) || cycle >= first_due)) begin
                watch_first = 1'b0;
                if (!(beat_valid && beat_ready && cycle == first_due)) begin
                    other_errs++;
                    $display("First beat did not arrive 3 cycles after the opcode was accepted");
                end
            end
            prev_stall = beat_valid && !beat_ready;
            prev_xfer  = beat_valid && beat_ready;
            prev_beat  = beat;
            drained    = (exp_q.size() == 0) && !active;
        end
    end

endmodule

// ==== bench/addr_ctrl_tb.sv ====
`timescale 1ns/1ps

module addr_ctrl_tb import cpu_ctrl_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;

    typedef struct packed {
        logic [7:0]  opc;
        addr_mode_e  mode;
        store_kind_e store;
        logic [2:0]  beats;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        op_valid;
    opcode_u     op;
    logic        carry_in;
    logic        beat_ready;
    logic        op_ready;
    logic        beat_valid;
    ctrl_beat_t  beat;
    logic        steady;
    logic        drained;
    int          value_errs;
    int          other_errs;
    logic [31:0] lfsr;
    row_t        rows[$];
    int          limit_cycles;

    addr_ctrl_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_valid   (op_valid),
        .op         (op),
        .carry_in   (carry_in),
        .beat_ready (beat_ready),
        .op_ready   (op_ready),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    addr_ctrl_checker u_check (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .carry_in   (carry_in),
        .seq_xfer   (DUT.seq_valid && DUT.seq_ready),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat       (beat),
        .steady     (steady),
        .drained    (drained),
        .value_errs (value_errs),
        .other_errs (other_errs)
    );

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic add_row(input logic [7:0] opc, input addr_mode_e m,
                           input store_kind_e k, input logic [2:0] n);
        row_t r;
        r.opc   = opc;
        r.mode  = m;
        r.store = k;
        r.beats = n;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // LDA in each cc=01 bbb slot
        add_row(8'hA1, IND_X, ST_NONE, 3'd4);
        add_row(8'hA5, ZPG, ST_NONE, 3'd1);
        add_row(8'hA9, IMMEDIATE, ST_NONE, 3'd1);
        add_row(8'hAD, ABSOLUTE, ST_NONE, 3'd2);
        add_row(8'hB1, IND_Y, ST_NONE, 3'd4);
        add_row(8'hB5, ZPG_X, ST_NONE, 3'd2);
        add_row(8'hB9, ABS_Y, ST_NONE, 3'd3);
        add_row(8'hBD, ABS_X, ST_NONE, 3'd3);
        // STA
        add_row(8'h81, IND_X, ST_ACC, 3'd4);
        add_row(8'h85, ZPG, ST_ACC, 3'd1);
        add_row(8'h89, IMMEDIATE, ST_ACC, 3'd1);
        add_row(8'h8D, ABSOLUTE, ST_ACC, 3'd2);
        add_row(8'h91, IND_Y, ST_ACC, 3'd4);
        add_row(8'h95, ZPG_X, ST_ACC, 3'd2);
        add_row(8'h99, ABS_Y, ST_ACC, 3'd3);
        add_row(8'h9D, ABS_X, ST_ACC, 3'd3);
        // STX and STY
        add_row(8'h86, ZPG, ST_X, 3'd1);
        add_row(8'h8E, ABSOLUTE, ST_X, 3'd2);
        add_row(8'h96, ZPG_Y, ST_X, 3'd2);
        add_row(8'h9E, ABS_Y, ST_X, 3'd3);
        add_row(8'h84, ZPG, ST_Y, 3'd1);
        add_row(8'h8C, ABSOLUTE, ST_Y, 3'd2);
        add_row(8'h94, ZPG_X, ST_Y, 3'd2);
        // LDX
        add_row(8'hA2, IMMEDIATE, ST_NONE, 3'd1);
        add_row(8'hA6, ZPG, ST_NONE, 3'd1);
        add_row(8'hAE, ABSOLUTE, ST_NONE, 3'd2);
        add_row(8'hB6, ZPG_Y, ST_NONE, 3'd2);
        add_row(8'hBE, ABS_Y, ST_NONE, 3'd3);
        // Implied, cc=11 and BIT abs
        add_row(8'hEA, IMPLIED, ST_NONE, 3'd1);
        add_row(8'hE8, IMPLIED, ST_NONE, 3'd1);
        add_row(8'hFF, IMPLIED, ST_NONE, 3'd1);
        add_row(8'h87, IMPLIED, ST_NONE, 3'd1);
        add_row(8'h2C, ABSOLUTE, ST_NONE, 3'd2);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_row(input row_t r, input logic allow_gap);
        logic gap;
        logic acc;
        if (allow_gap) begin
            take_bit(gap);
            if (gap) begin
                op_valid = 1'b0;
                @(posedge clk);
                #1;
            end
        end
        u_check.expect_op(r.mode, r.store, r.beats);
        op_valid = 1'b1;
        op.raw   = r.opc;
        acc      = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = op_ready;
            @(posedge clk);
        end
        #1;
        op_valid = 1'b0;
    endtask

    task automatic wait_drain();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = drained;
            @(posedge clk);
        end
        #1;
    endtask

    task automatic print_counts();
        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Back-pressure and carry drawn at each edge and driven 1 ns later
    initial begin
        logic c;
        logic b0;
        logic b1;
        logic r;
        forever begin
            @(posedge clk);
            take_bit(c);
            r = 1'b1;
            if (!steady) begin
                take_bit(b0);
                take_bit(b1);
                r = b0 | b1;
            end
            #1;
            carry_in   = c;
            beat_ready = r;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        print_counts();
        $display("test failed");
        $finish;
    end

    initial begin
        int total_beats;
        lfsr         = 32'hc4d4_098e;
        arst_n       = 1'b0;
        op_valid     = 1'b0;
        op           = '0;
        carry_in     = 1'b0;
        beat_ready   = 1'b0;
        steady       = 1'b0;
        limit_cycles = 0;
        total_beats  = 0;
        build_table();
        foreach (rows[i]) begin
            total_beats += 2 * rows[i].beats;
        end
        limit_cycles = 20 * total_beats + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        // Random back-pressure and gaps
        foreach (rows[i]) begin
            send_row(rows[i], 1'b1);
        end
        wait_drain();
        // Back to back with beat_ready held high
        steady = 1'b1;
        @(posedge clk);
        #1;
        foreach (rows[i]) begin
            send_row(rows[i], 1'b0);
        end
        wait_drain();
        print_counts();
        if (value_errs + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/cpu_ctrl_pkg.sv
src/opcode_decode.sv
src/addr_mode_seq.sv
src/ctrl_out_slice.sv
src/addr_ctrl_top.sv
bench/addr_ctrl_checker.sv
bench/addr_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: addr_ctrl

sources:
  - src/cpu_ctrl_pkg.sv
  - src/opcode_decode.sv
  - src/addr_mode_seq.sv
  - src/ctrl_out_slice.sv
  - src/addr_ctrl_top.sv
  - target: test
    files:
      - bench/addr_ctrl_checker.sv
      - bench/addr_ctrl_tb.sv
